// ==== filelist.f ====
+incdir+rtl
rtl/pkt_pkg.sv
rtl/reg_pkg.sv
rtl/udp_ifs.sv
rtl/input_arbiter.sv
rtl/output_port_lookup.sv
rtl/output_queues.sv
rtl/udp_reg_master.sv
rtl/user_data_path.sv
bench/udp_assert.sv
bench/tb_user_data_path.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the user data path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f filelist.f --top-module tb_user_data_path -o sim_udp
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

output=$(./obj_dir/sim_udp)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
   exit 0
fi
exit 1

// ==== bench/tb_user_data_path.sv ====
// -----------------------------------------------
// User data path testbench
// Random packets under back-pressure, loopback
// mode and register ring accesses
// -----------------------------------------------
`include "udp_config.svh"

module tb_user_data_path;
   import pkt_pkg::*;
   import reg_pkg::*;

   localparam int NP      = `UDP_NUM_PORTS;
   localparam int TIMEOUT = 500;

   logic                           clk;
   logic                           reset;
   logic [`UDP_DATA_WIDTH-1:0]     in_data [NP];
   logic [`UDP_CTRL_WIDTH-1:0]     in_ctrl [NP];
   logic [NP-1:0]                  in_wr;
   logic [NP-1:0]                  in_rdy;
   logic [`UDP_DATA_WIDTH-1:0]     out_data [NP];
   logic [`UDP_CTRL_WIDTH-1:0]     out_ctrl [NP];
   logic [NP-1:0]                  out_wr;
   logic [NP-1:0]                  out_rdy;
   logic                           reg_req;
   reg_op_e                        reg_rd_wr_l;
   logic [`UDP_REG_ADDR_WIDTH-1:0] reg_addr;
   logic [`UDP_REG_DATA_WIDTH-1:0] reg_wr_data;
   logic                           reg_ack;
   logic [`UDP_REG_DATA_WIDTH-1:0] reg_rd_data;

   integer                         seed;
   int                             errors;
   int                             tot_in;
   int                             tot_out;
   int                             sent_hdr [NP];
   int                             recv_hdr [NP];
   logic [`UDP_REG_DATA_WIDTH-1:0] rd;

   user_data_path i_dut (
      .clk         (clk),
      .reset       (reset),
      .in_data     (in_data),
      .in_ctrl     (in_ctrl),
      .in_wr       (in_wr),
      .in_rdy      (in_rdy),
      .out_data    (out_data),
      .out_ctrl    (out_ctrl),
      .out_wr      (out_wr),
      .out_rdy     (out_rdy),
      .reg_req     (reg_req),
      .reg_rd_wr_l (reg_rd_wr_l),
      .reg_addr    (reg_addr),
      .reg_wr_data (reg_wr_data),
      .reg_ack     (reg_ack),
      .reg_rd_data (reg_rd_data)
   );

   bind user_data_path udp_assert i_udp_assert (
      .clk      (clk),
      .reset    (reset),
      .in_data  (in_data),
      .in_ctrl  (in_ctrl),
      .in_wr    (in_wr),
      .in_rdy   (in_rdy),
      .out_data (out_data),
      .out_ctrl (out_ctrl),
      .out_wr   (out_wr),
      .out_rdy  (out_rdy),
      .reg_req  (reg_req),
      .reg_ack  (reg_ack)
   );

   initial clk = 1'b0;
   always #2 clk = ~clk;

   // Random back-pressure on every output
   always @(posedge clk)
   begin
      #1;
      out_rdy = NP'($random(seed));
   end

   // Word and header counts at the ports
   always @(posedge clk)
   begin
      if (!reset)
      begin
         for (int k = 0; k < NP; k++)
         begin
            if (in_wr[k] && in_rdy[k])
            begin
               tot_in++;
               if (in_ctrl[k] == CTRL_HDR)
                  sent_hdr[k]++;
            end
            if (out_wr[k] && out_rdy[k])
            begin
               tot_out++;
               if (out_ctrl[k] == CTRL_HDR)
                  recv_hdr[k]++;
            end
         end
      end
   end

   task automatic check_value(input string name, input longint expected, input longint actual);
      if (expected != actual)
      begin
         $display("error: %s expected %0d actual %0d", name, expected, actual);
         errors++;
      end
   endtask

   task automatic clear_counts();
      for (int k = 0; k < NP; k++)
      begin
         sent_hdr[k] = 0;
         recv_hdr[k] = 0;
      end
   endtask

   // Holds the word until the port is ready
   task automatic send_word(input int port, input logic [7:0] ctrl, input logic [63:0] data);
      int t;
      t = 0;
      in_data[port] = data;
      in_ctrl[port] = ctrl;
      in_wr[port]   = 1'b1;
      @(negedge clk);
      while (!in_rdy[port] && t < TIMEOUT)
      begin
         @(negedge clk);
         t++;
      end
      if (t == TIMEOUT)
      begin
         $display("timeout: input port %0d never became ready", port);
         errors++;
      end
      @(posedge clk);
      #1;
   endtask

   // Header, two payload words, end word
   task automatic send_packet(input int port);
      send_word(port, CTRL_HDR, {$random(seed), $random(seed)});
      send_word(port, CTRL_PAYLOAD, {$random(seed), $random(seed)});
      send_word(port, CTRL_PAYLOAD, {$random(seed), $random(seed)});
      send_word(port, 8'h0f, {$random(seed), $random(seed)});
      in_wr[port] = 1'b0;
   endtask

   task automatic wait_drain();
      int t;
      t = 0;
      @(negedge clk);
      while (tot_out != tot_in && t < TIMEOUT)
      begin
         @(negedge clk);
         t++;
      end
      if (t == TIMEOUT)
      begin
         $display("timeout: packets still inside the data path");
         errors++;
      end
      @(posedge clk);
      #1;
   endtask

   task automatic send_burst(input int n);
      int port;
      for (int i = 0; i < n; i++)
      begin
         port = int'($unsigned($random(seed)) % NP);
         send_packet(port);
      end
      wait_drain();
   endtask

   task automatic reg_access(input reg_op_e op, input logic [7:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
      int t;
      t = 0;
      reg_req     = 1'b1;
      reg_rd_wr_l = op;
      reg_addr    = addr;
      reg_wr_data = wdata;
      @(posedge clk);
      #1;
      reg_req = 1'b0;
      @(negedge clk);
      while (!reg_ack && t < TIMEOUT)
      begin
         @(negedge clk);
         t++;
      end
      if (t == TIMEOUT)
      begin
         $display("timeout: no register ack for address %h", addr);
         errors++;
      end
      rdata = reg_rd_data;
      @(posedge clk);
      #1;
   endtask

   initial
   begin
      seed        = 47;
      errors      = 0;
      tot_in      = 0;
      tot_out     = 0;
      reset       = 1'b1;
      in_wr       = '0;
      out_rdy     = '1;
      reg_req     = 1'b0;
      reg_rd_wr_l = REG_READ;
      reg_addr    = '0;
      reg_wr_data = '0;
      for (int k = 0; k < NP; k++)
      begin
         in_data[k] = '0;
         in_ctrl[k] = '0;
      end
      clear_counts();
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;

      // Default mode, partner port routing
      send_burst(12);
      for (int k = 0; k < NP; k++)
         check_value($sformatf("default route port %0d", k), sent_hdr[k ^ 1], recv_hdr[k]);

      // Loopback mode
      reg_access(REG_WRITE, {BLK_LUT, REG_LUT_MODE}, 32'd1, rd);
      reg_access(REG_READ, {BLK_LUT, REG_LUT_MODE}, 32'd0, rd);
      check_value("loopback mode", 1, rd);
      clear_counts();
      send_burst(8);
      for (int k = 0; k < NP; k++)
         check_value($sformatf("loopback port %0d", k), sent_hdr[k], recv_hdr[k]);

      // 20 packets of 4 words
      check_value("words in", 80, tot_in);
      check_value("words out", 80, tot_out);

      // -----------------------------------------------
      // Packet counters and an unmapped address
      // -----------------------------------------------
      reg_access(REG_READ, {BLK_ARB, REG_PKT_COUNT}, 32'd0, rd);
      check_value("arbiter packet count", 20, rd);
      reg_access(REG_READ, {BLK_LUT, REG_PKT_COUNT}, 32'd0, rd);
      check_value("lookup packet count", 20, rd);
      reg_access(REG_READ, {BLK_OQ, REG_PKT_COUNT}, 32'd0, rd);
      check_value("queue packet count", 20, rd);
      reg_access(REG_READ, 8'h05, 32'd0, rd);
      check_value("unmapped read", 64'hffff_ffff, rd);

      $display("run complete with %0d errors", errors);
      if (errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

// ==== bench/udp_assert.sv ====
// -----------------------------------------------
// User data path assertions
// Routing, stream hold, packet order, register
// ring timing and reset state
// -----------------------------------------------
`include "udp_config.svh"

module udp_assert (
   input logic                           clk,
   input logic                           reset,
   input logic [`UDP_DATA_WIDTH-1:0]     in_data [`UDP_NUM_PORTS],
   input logic [`UDP_CTRL_WIDTH-1:0]     in_ctrl [`UDP_NUM_PORTS],
   input logic [`UDP_NUM_PORTS-1:0]      in_wr,
   input logic [`UDP_NUM_PORTS-1:0]      in_rdy,
   input logic [`UDP_DATA_WIDTH-1:0]     out_data [`UDP_NUM_PORTS],
   input logic [`UDP_CTRL_WIDTH-1:0]     out_ctrl [`UDP_NUM_PORTS],
   input logic [`UDP_NUM_PORTS-1:0]      out_wr,
   input logic [`UDP_NUM_PORTS-1:0]      out_rdy,
   input logic                           reg_req,
   input logic                           reg_ack
);
   import pkt_pkg::*;

   logic [`UDP_NUM_PORTS-1:0] in_pkt;
   logic [1:0]                busy_cnt;
   logic                      accepted;

   // Host request taken only while the ring is idle
   assign accepted = reg_req && busy_cnt == 2'd0;

   always_ff @(posedge clk)
   begin
      if (reset)
         busy_cnt <= 2'd0;
      else if (accepted)
         busy_cnt <= 2'd3;
      else if (busy_cnt != 2'd0)
         busy_cnt <= busy_cnt - 2'd1;
   end

   // Open packet per output port
   always_ff @(posedge clk)
   begin
      if (reset)
         in_pkt <= '0;
      else
      begin
         for (int k = 0; k < `UDP_NUM_PORTS; k++)
         begin
            if (out_wr[k] && out_rdy[k])
            begin
               if (out_ctrl[k] == CTRL_HDR)
                  in_pkt[k] <= 1'b1;
               else if (out_ctrl[k] != CTRL_PAYLOAD)
                  in_pkt[k] <= 1'b0;
            end
         end
      end
   end

   // -----------------------------------------------
   // Per port checks
   // -----------------------------------------------
   for (genvar k = 0; k < `UDP_NUM_PORTS; k++)
   begin : g_port
      a_dst: assert property (@(posedge clk) disable iff (reset)
         out_wr[k] && out_ctrl[k] == CTRL_HDR |-> out_data[k][15:0] == 16'(1 << k))
         else $error("header on port %0d has wrong dst_ports", k);

      a_src: assert property (@(posedge clk) disable iff (reset)
         out_wr[k] && out_ctrl[k] == CTRL_HDR
         |-> out_data[k][31:16] == 16'(k) || out_data[k][31:16] == 16'(k ^ 1))
         else $error("header on port %0d has unexpected src_port", k);

      // A header only where no packet is open
      a_order: assert property (@(posedge clk) disable iff (reset)
         out_wr[k] |-> (out_ctrl[k] == CTRL_HDR) == !in_pkt[k])
         else $error("packet on port %0d interleaved or missing its header", k);

      a_out_hold: assert property (@(posedge clk) disable iff (reset)
         out_wr[k] && !out_rdy[k]
         |=> out_wr[k] && $stable(out_data[k]) && $stable(out_ctrl[k]))
         else $error("output word on port %0d changed under back-pressure", k);

      a_in_hold: assert property (@(posedge clk) disable iff (reset)
         in_wr[k] && !in_rdy[k]
         |=> in_wr[k] && $stable(in_data[k]) && $stable(in_ctrl[k]))
         else $error("input word on port %0d changed before it was taken", k);
   end

   // -----------------------------------------------
   // Register ring and reset
   // -----------------------------------------------
   a_ack_timing: assert property (@(posedge clk) disable iff (reset)
      reg_ack == $past(accepted, 4))
      else $error("reg_ack not exactly 4 cycles after an accepted reg_req");

   a_ack_pulse: assert property (@(posedge clk) disable iff (reset)
      reg_ack |=> !reg_ack)
      else $error("reg_ack longer than one cycle");

   a_reset_state: assert property (@(posedge clk)
      reset |=> out_wr == '0 && !reg_ack)
      else $error("out_wr or reg_ack active after reset");

endmodule

// ==== rtl/user_data_path.sv ====
// -----------------------------------------------
// User data path
// Arbiter, port lookup and output queues on the
// packet path, all on one register ring
// -----------------------------------------------
`include "udp_config.svh"

module user_data_path (
   input  logic                           clk,
   input  logic                           reset,
   input  logic [`UDP_DATA_WIDTH-1:0]     in_data [`UDP_NUM_PORTS],
   input  logic [`UDP_CTRL_WIDTH-1:0]     in_ctrl [`UDP_NUM_PORTS],
   input  logic [`UDP_NUM_PORTS-1:0]      in_wr,
   output logic [`UDP_NUM_PORTS-1:0]      in_rdy,
   output logic [`UDP_DATA_WIDTH-1:0]     out_data [`UDP_NUM_PORTS],
   output logic [`UDP_CTRL_WIDTH-1:0]     out_ctrl [`UDP_NUM_PORTS],
   output logic [`UDP_NUM_PORTS-1:0]      out_wr,
   input  logic [`UDP_NUM_PORTS-1:0]      out_rdy,
   input  logic                           reg_req,
   input  reg_pkg::reg_op_e               reg_rd_wr_l,
   input  logic [`UDP_REG_ADDR_WIDTH-1:0] reg_addr,
   input  logic [`UDP_REG_DATA_WIDTH-1:0] reg_wr_data,
   output logic                           reg_ack,
   output logic [`UDP_REG_DATA_WIDTH-1:0] reg_rd_data
);
   // Packet path
   pkt_stream_if arb_to_lut ();
   pkt_stream_if lut_to_oq ();

   // Register ring, master first and last
   reg_ring_if reg_master_to_arb ();
   reg_ring_if reg_arb_to_lut ();
   reg_ring_if reg_lut_to_oq ();
   reg_ring_if reg_oq_to_master ();

   input_arbiter i_input_arbiter (
      .clk     (clk),
      .reset   (reset),
      .in_data (in_data),
      .in_ctrl (in_ctrl),
      .in_wr   (in_wr),
      .in_rdy  (in_rdy),
      .out     (arb_to_lut),
      .reg_in  (reg_master_to_arb),
      .reg_out (reg_arb_to_lut)
   );

   output_port_lookup i_output_port_lookup (
      .clk     (clk),
      .reset   (reset),
      .in      (arb_to_lut),
      .out     (lut_to_oq),
      .reg_in  (reg_arb_to_lut),
      .reg_out (reg_lut_to_oq)
   );

   output_queues i_output_queues (
      .clk      (clk),
      .reset    (reset),
      .in       (lut_to_oq),
      .out_data (out_data),
      .out_ctrl (out_ctrl),
      .out_wr   (out_wr),
      .out_rdy  (out_rdy),
      .reg_in   (reg_lut_to_oq),
      .reg_out  (reg_oq_to_master)
   );

   udp_reg_master i_udp_reg_master (
      .clk         (clk),
      .reset       (reset),
      .reg_req     (reg_req),
      .reg_rd_wr_l (reg_rd_wr_l),
      .reg_addr    (reg_addr),
      .reg_wr_data (reg_wr_data),
      .reg_ack     (reg_ack),
      .reg_rd_data (reg_rd_data),
      .ring_out    (reg_master_to_arb),
      .ring_in     (reg_oq_to_master)
   );

endmodule

// ==== rtl/udp_reg_master.sv ====
// -----------------------------------------------
// Register ring master
// Injects host accesses into the ring and returns
// the reply when the transaction comes back
// -----------------------------------------------
`include "udp_config.svh"

module udp_reg_master (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           reg_req,
   input  reg_pkg::reg_op_e               reg_rd_wr_l,
   input  logic [`UDP_REG_ADDR_WIDTH-1:0] reg_addr,
   input  logic [`UDP_REG_DATA_WIDTH-1:0] reg_wr_data,
   output logic                           reg_ack,
   output logic [`UDP_REG_DATA_WIDTH-1:0] reg_rd_data,
   reg_ring_if.downstream                 ring_out,
   reg_ring_if.upstream                   ring_in
);
   typedef enum logic {MST_IDLE, MST_WAIT} mst_state_e;

   mst_state_e                    state;
   logic [`UDP_REG_SRC_WIDTH-1:0] tag;
   logic                          done;

   // Requests while one is outstanding are dropped
   assign ring_out.req     = reg_req && state == MST_IDLE;
   assign ring_out.ack     = 1'b0;
   assign ring_out.rd_wr_l = reg_rd_wr_l;
   assign ring_out.addr    = reg_addr;
   assign ring_out.data    = reg_wr_data;
   assign ring_out.src     = tag;

   // Tag match guards against a stale reply
   assign done = state == MST_WAIT && ring_in.req && ring_in.src == tag;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state   <= MST_IDLE;
         tag     <= '0;
         reg_ack <= 1'b0;
      end
      else
      begin
         reg_ack <= done;
         if (ring_out.req)
            state <= MST_WAIT;
         else if (done)
         begin
            state <= MST_IDLE;
            tag   <= tag + 1'b1;
         end
      end
   end

   // Unclaimed accesses read back as all ones
   always_ff @(posedge clk)
   begin
      if (done)
         reg_rd_data <= ring_in.ack ? ring_in.data : `UDP_REG_UNMAPPED;
   end

endmodule

// ==== rtl/output_queues.sv ====
// -----------------------------------------------
// Output queues
// One FIFO per output port, filled by packet
// destination and drained under back-pressure
// -----------------------------------------------
`include "udp_config.svh"

module output_queues (
   input  logic                       clk,
   input  logic                       reset,
   pkt_stream_if.sink                 in,
   output logic [`UDP_DATA_WIDTH-1:0] out_data [`UDP_NUM_PORTS],
   output logic [`UDP_CTRL_WIDTH-1:0] out_ctrl [`UDP_NUM_PORTS],
   output logic [`UDP_NUM_PORTS-1:0]  out_wr,
   input  logic [`UDP_NUM_PORTS-1:0]  out_rdy,
   reg_ring_if.upstream               reg_in,
   reg_ring_if.downstream             reg_out
);
   import pkt_pkg::*;
   import reg_pkg::*;

   localparam int AW = $clog2(`UDP_OQ_DEPTH);
   localparam int FW = `UDP_DATA_WIDTH + `UDP_CTRL_WIDTH;

   logic                           take;
   logic                           is_hdr;
   pkt_hdr_t                       in_hdr;
   logic [`UDP_NUM_PORTS-1:0]      dst_reg;
   logic [`UDP_NUM_PORTS-1:0]      dst_sel;
   logic [`UDP_NUM_PORTS-1:0]      full;
   logic [`UDP_REG_DATA_WIDTH-1:0] pkt_count;
   logic                           reg_hit;

   // Any full queue stalls the whole input
   assign in.rdy  = !(|full);
   assign take    = in.wr && in.rdy;
   assign is_hdr  = in.ctrl == CTRL_HDR;
   assign in_hdr  = in.data;
   assign dst_sel = is_hdr ? in_hdr.dst_ports[`UDP_NUM_PORTS-1:0] : dst_reg;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         dst_reg   <= '0;
         pkt_count <= '0;
      end
      else if (take && is_hdr)
      begin
         dst_reg   <= dst_sel;
         pkt_count <= pkt_count + 1'b1;
      end
   end

   for (genvar p = 0; p < `UDP_NUM_PORTS; p++)
   begin : g_queue
      logic [FW-1:0] mem [`UDP_OQ_DEPTH];
      logic [AW-1:0] wr_ptr;
      logic [AW-1:0] rd_ptr;
      logic [AW:0]   count;
      logic          push;
      logic          pop;

      assign push    = take && dst_sel[p];
      assign pop     = out_wr[p] && out_rdy[p];
      assign full[p] = count == (AW + 1)'(`UDP_OQ_DEPTH);
      assign out_wr[p] = count != '0;
      assign {out_ctrl[p], out_data[p]} = mem[rd_ptr];

      always_ff @(posedge clk)
      begin
         if (reset)
         begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
         end
         else
         begin
            if (push)
               wr_ptr <= wr_ptr + 1'b1;
            if (pop)
               rd_ptr <= rd_ptr + 1'b1;
            count <= count + (AW + 1)'(push) - (AW + 1)'(pop);
         end
      end

      always_ff @(posedge clk)
      begin
         if (push)
            mem[wr_ptr] <= {in.ctrl, in.data};
      end
   end

   // -----------------------------------------------
   // Register ring stage
   // -----------------------------------------------
   assign reg_hit = reg_in.req && !reg_in.ack && reg_block(reg_in.addr) == BLK_OQ
                    && reg_offset(reg_in.addr) == REG_PKT_COUNT;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         reg_out.req <= 1'b0;
         reg_out.ack <= 1'b0;
      end
      else
      begin
         reg_out.req <= reg_in.req;
         reg_out.ack <= reg_in.ack || reg_hit;
      end
   end

   always_ff @(posedge clk)
   begin
      reg_out.rd_wr_l <= reg_in.rd_wr_l;
      reg_out.addr    <= reg_in.addr;
      reg_out.src     <= reg_in.src;
      if (reg_hit && reg_in.rd_wr_l == REG_READ)
         reg_out.data <= pkt_count;
      else
         reg_out.data <= reg_in.data;
   end

endmodule

// ==== rtl/output_port_lookup.sv ====
// -----------------------------------------------
// Output port lookup
// Sends each packet to its partner port, or back
// to its source port in loopback mode
// -----------------------------------------------
`include "udp_config.svh"

module output_port_lookup (
   input  logic           clk,
   input  logic           reset,
   pkt_stream_if.sink     in,
   pkt_stream_if.source   out,
   reg_ring_if.upstream   reg_in,
   reg_ring_if.downstream reg_out
);
   import pkt_pkg::*;
   import reg_pkg::*;

   logic                           take;
   logic                           is_hdr;
   logic [15:0]                    dst;
   pkt_hdr_t                       hdr;
   logic                           loopback;
   logic [`UDP_REG_DATA_WIDTH-1:0] pkt_count;
   logic                           reg_hit;
   logic                           reg_rd;
   logic                           is_mode;

   // Stalls together with downstream
   assign in.rdy = !out.wr || out.rdy;
   assign take   = in.wr && in.rdy;
   assign is_hdr = in.ctrl == CTRL_HDR;

   // Even ports pair with the odd port above them
   always_comb
   begin
      hdr = in.data;
      dst = loopback ? hdr.src_port : hdr.src_port ^ 16'd1;
      hdr.dst_ports = 16'd1 << dst;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         out.wr    <= 1'b0;
         pkt_count <= '0;
      end
      else
      begin
         if (take)
            out.wr <= 1'b1;
         else if (out.rdy)
            out.wr <= 1'b0;
         if (take && is_hdr)
            pkt_count <= pkt_count + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (take)
      begin
         if (is_hdr)
            out.data <= hdr;
         else
            out.data <= in.data;
         out.ctrl <= in.ctrl;
      end
   end

   // -----------------------------------------------
   // Register ring stage and mode register
   // -----------------------------------------------
   assign is_mode = reg_offset(reg_in.addr) == REG_LUT_MODE;
   assign reg_hit = reg_in.req && !reg_in.ack && reg_block(reg_in.addr) == BLK_LUT
                    && (is_mode || reg_offset(reg_in.addr) == REG_PKT_COUNT);
   assign reg_rd  = reg_in.rd_wr_l == REG_READ;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         reg_out.req <= 1'b0;
         reg_out.ack <= 1'b0;
         loopback    <= 1'b0;
      end
      else
      begin
         reg_out.req <= reg_in.req;
         reg_out.ack <= reg_in.ack || reg_hit;
         if (reg_hit && !reg_rd && is_mode)
            loopback <= reg_in.data[0];
      end
   end

   always_ff @(posedge clk)
   begin
      reg_out.rd_wr_l <= reg_in.rd_wr_l;
      reg_out.addr    <= reg_in.addr;
      reg_out.src     <= reg_in.src;
      if (reg_hit && reg_rd)
         reg_out.data <= is_mode ? `UDP_REG_DATA_WIDTH'(loopback) : pkt_count;
      else
         reg_out.data <= reg_in.data;
   end

endmodule

// ==== rtl/input_arbiter.sv ====
// -----------------------------------------------
// Input arbiter
// Round-robin over the input ports, one packet
// per grant, stamps the source port in the header
// -----------------------------------------------
`include "udp_config.svh"

module input_arbiter (
   input  logic                       clk,
   input  logic                       reset,
   input  logic [`UDP_DATA_WIDTH-1:0] in_data [`UDP_NUM_PORTS],
   input  logic [`UDP_CTRL_WIDTH-1:0] in_ctrl [`UDP_NUM_PORTS],
   input  logic [`UDP_NUM_PORTS-1:0]  in_wr,
   output logic [`UDP_NUM_PORTS-1:0]  in_rdy,
   pkt_stream_if.source               out,
   reg_ring_if.upstream               reg_in,
   reg_ring_if.downstream             reg_out
);
   import pkt_pkg::*;
   import reg_pkg::*;

   localparam int PW = $clog2(`UDP_NUM_PORTS);

   typedef enum logic {ARB_IDLE, ARB_IN_PKT} arb_state_e;

   arb_state_e                     state;
   logic [PW-1:0]                  cur;
   logic [PW-1:0]                  nxt;
   logic                           found;
   logic                           take;
   logic                           is_hdr;
   logic                           is_end;
   pkt_hdr_t                       hdr;
   logic [`UDP_REG_DATA_WIDTH-1:0] pkt_count;
   logic                           reg_hit;

   // Next requesting port after the last one served
   always_comb
   begin
      nxt = cur;
      found = 1'b0;
      for (int i = 1; i <= `UDP_NUM_PORTS; i++)
      begin
         if (!found && in_wr[(int'(cur) + i) % `UDP_NUM_PORTS])
         begin
            nxt = PW'((int'(cur) + i) % `UDP_NUM_PORTS);
            found = 1'b1;
         end
      end
   end

   always_comb
   begin
      in_rdy = '0;
      if (state == ARB_IN_PKT)
         in_rdy[cur] = !out.wr || out.rdy;
   end

   assign take   = in_wr[cur] && in_rdy[cur];
   assign is_hdr = in_ctrl[cur] == CTRL_HDR;
   assign is_end = !is_hdr && in_ctrl[cur] != CTRL_PAYLOAD;

   always_comb
   begin
      hdr = in_data[cur];
      hdr.src_port = 16'(cur);
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state     <= ARB_IDLE;
         cur       <= PW'(`UDP_NUM_PORTS - 1);
         out.wr    <= 1'b0;
         pkt_count <= '0;
      end
      else
      begin
         if (state == ARB_IDLE && found)
         begin
            cur   <= nxt;
            state <= ARB_IN_PKT;
         end
         else if (take && is_end)
            state <= ARB_IDLE;

         if (take)
            out.wr <= 1'b1;
         else if (out.rdy)
            out.wr <= 1'b0;

         if (take && is_hdr)
            pkt_count <= pkt_count + 1'b1;
      end
   end

   // Output word register
   always_ff @(posedge clk)
   begin
      if (take)
      begin
         if (is_hdr)
            out.data <= hdr;
         else
            out.data <= in_data[cur];
         out.ctrl <= in_ctrl[cur];
      end
   end

   // -----------------------------------------------
   // Register ring stage
   // -----------------------------------------------
   assign reg_hit = reg_in.req && !reg_in.ack && reg_block(reg_in.addr) == BLK_ARB
                    && reg_offset(reg_in.addr) == REG_PKT_COUNT;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         reg_out.req <= 1'b0;
         reg_out.ack <= 1'b0;
      end
      else
      begin
         reg_out.req <= reg_in.req;
         reg_out.ack <= reg_in.ack || reg_hit;
      end
   end

   always_ff @(posedge clk)
   begin
      reg_out.rd_wr_l <= reg_in.rd_wr_l;
      reg_out.addr    <= reg_in.addr;
      reg_out.src     <= reg_in.src;
      if (reg_hit && reg_in.rd_wr_l == REG_READ)
         reg_out.data <= pkt_count;
      else
         reg_out.data <= reg_in.data;
   end

endmodule

// ==== rtl/udp_ifs.sv ====
// -----------------------------------------------
// Data path interfaces
// Packet word stream and register ring hop
// -----------------------------------------------
`include "udp_config.svh"

// Word moves when wr and rdy are both high
interface pkt_stream_if;
   logic [`UDP_DATA_WIDTH-1:0] data;
   logic [`UDP_CTRL_WIDTH-1:0] ctrl;
   logic                       wr;
   logic                       rdy;

   modport source (output data, ctrl, wr, input rdy);
   modport sink (input data, ctrl, wr, output rdy);
endinterface

// One ring hop, req is a single-cycle pulse
interface reg_ring_if;
   logic                           req;
   logic                           ack;
   logic                           rd_wr_l;
   logic [`UDP_REG_ADDR_WIDTH-1:0] addr;
   logic [`UDP_REG_DATA_WIDTH-1:0] data;
   logic [`UDP_REG_SRC_WIDTH-1:0]  src;

   modport upstream (input req, ack, rd_wr_l, addr, data, src);
   modport downstream (output req, ack, rd_wr_l, addr, data, src);
endinterface

// ==== rtl/reg_pkg.sv ====
// -----------------------------------------------
// Register map definitions
// Stage block codes, offsets and ring operations
// -----------------------------------------------
`include "udp_config.svh"

package reg_pkg;

   // Upper address nibble selects the stage
   typedef enum logic [3:0] {
      BLK_NONE = 4'd0,
      BLK_ARB  = 4'd1,
      BLK_LUT  = 4'd2,
      BLK_OQ   = 4'd3
   } reg_block_e;

   // Meaning of the ring rd_wr_l bit
   typedef enum logic {
      REG_WRITE = 1'b0,
      REG_READ  = 1'b1
   } reg_op_e;

   // Lower address nibble
   localparam logic [3:0] REG_PKT_COUNT = 4'd0;
   localparam logic [3:0] REG_LUT_MODE  = 4'd1;

   function automatic reg_block_e reg_block(input logic [`UDP_REG_ADDR_WIDTH-1:0] addr);
      return reg_block_e'(addr[`UDP_REG_ADDR_WIDTH-1 -: 4]);
   endfunction

   function automatic logic [3:0] reg_offset(input logic [`UDP_REG_ADDR_WIDTH-1:0] addr);
      return addr[3:0];
   endfunction

endpackage

// ==== rtl/pkt_pkg.sv ====
// -----------------------------------------------
// Packet format definitions
// Control word codes and header field layout
// -----------------------------------------------
`include "udp_config.svh"

package pkt_pkg;

   // Control field of each word
   // Any other nonzero value is the end word byte mask
   typedef enum logic [`UDP_CTRL_WIDTH-1:0] {
      CTRL_PAYLOAD = {`UDP_CTRL_WIDTH{1'b0}},
      CTRL_HDR     = {`UDP_CTRL_WIDTH{1'b1}}
   } pkt_ctrl_e;

   // Header word, one-hot destination in the low bits
   typedef struct packed {
      logic [`UDP_DATA_WIDTH-33:0] unused;
      logic [15:0]                 src_port;
      logic [15:0]                 dst_ports;
   } pkt_hdr_t;

endpackage

// ==== rtl/udp_config.svh ====
// -----------------------------------------------
// User data path configuration
// Widths, port count and queue sizing
// -----------------------------------------------
`ifndef UDP_CONFIG_SVH
`define UDP_CONFIG_SVH

// Packet word
`define UDP_DATA_WIDTH      64
`define UDP_CTRL_WIDTH      8

// Ports and output queue sizing
`define UDP_NUM_PORTS       4
`define UDP_OQ_DEPTH        16

// Register ring
`define UDP_REG_ADDR_WIDTH  8
`define UDP_REG_DATA_WIDTH  32
`define UDP_REG_SRC_WIDTH   2
`define UDP_REG_UNMAPPED    32'hffff_ffff

`endif
